/* hw/isaPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction set of the register machine
// opcodes, field widths and both views of the 16-bit word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isaPkg;

	// register file geometry
	localparam int regCount = 8;
	localparam int regIdxBits = 3;

	// instruction word layout
	localparam int instrBits = 16;
	localparam int opBits = 4;
	localparam int immBits = 6;
	localparam int spareBits = instrBits - opBits - 3 * regIdxBits;

	typedef enum logic [opBits-1:0]
	{
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		// constant form from here on
		ADDI = 4'h5,
		LDI  = 4'h6,
		// memory access, address in ra or constant
		LD   = 4'h7,
		ST   = 4'h8,
		STA  = 4'h9,
		INC  = 4'ha,
		DEC  = 4'hb,
		NOP  = 4'hf
	} opcode_t;

	// op, rd and ra sit at the same bits in both views
	typedef union packed
	{
		struct packed
		{
			opcode_t op;
			logic [regIdxBits-1:0] rd;
			logic [regIdxBits-1:0] ra;
			logic [regIdxBits-1:0] rb;
			logic [spareBits-1:0] spare;
		} regForm;
		// low six bits are a signed constant
		struct packed
		{
			opcode_t op;
			logic [regIdxBits-1:0] rd;
			logic [regIdxBits-1:0] ra;
			logic signed [immBits-1:0] imm;
		} immForm;
	} instrWord_t;

endpackage

/* hw/dpPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath control encodings
// ALU operations and memory address sources
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dpPkg;

	localparam int aluOpBits = 3;
	localparam int addrSrcBits = 2;

	// ALU function select
	typedef enum logic [aluOpBits-1:0]
	{
		// result is the B operand unchanged
		PASSB = 3'd0,
		ADD   = 3'd1,
		SUB   = 3'd2,
		AND   = 3'd3,
		OR    = 3'd4,
		XOR   = 3'd5
	} aluOp_t;

	// where the memory address bus is taken from
	typedef enum logic [addrSrcBits-1:0]
	{
		// register picked by addrRegSel
		SRC_REG   = 2'd0,
		// ALU result, same cycle
		SRC_ALU   = 2'd1,
		// sign-extended instruction constant
		SRC_CONST = 2'd2
	} addrSrc_t;

endpackage

/* hw/regCell.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one datapath register
// priority load from ALU, memory or constant, else inc/dec
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module regCell
#(
	parameter int wordBits = 16
)
(
	input  logic CLK,
	input  logic arstN,
	input  logic [wordBits-1:0] inAlu,
	input  logic [wordBits-1:0] inMem,
	input  logic [wordBits-1:0] inConst,
	// all strobes active low
	input  logic ldAluN,
	input  logic ldMemN,
	input  logic ldConstN,
	input  logic incN,
	input  logic decN,
	output logic [wordBits-1:0] q
);

	// ALU load wins, decrement is last
	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
			q <= '0;
		else if (!ldAluN)
			q <= inAlu;
		else if (!ldMemN)
			q <= inMem;
		else if (!ldConstN)
			q <= inConst;
		// counting only with no load pending
		else if (!incN)
			q <= q + wordBits'(1);
		else if (!decN)
			// zero wraps to all ones
			q <= q - wordBits'(1);
	end

endmodule

/* hw/regFile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eight-entry register file
// ALU A/B read ports, memory data port, address mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module regFile
#(
	parameter int wordBits = 16
)
(
	input  logic CLK,
	input  logic arstN,
	// write data sources
	input  logic [wordBits-1:0] inAlu,
	input  logic [wordBits-1:0] inMem,
	input  logic [wordBits-1:0] inConst,
	// per-register strobes, active low
	input  logic [isaPkg::regCount-1:0] ldAluN,
	input  logic [isaPkg::regCount-1:0] ldMemN,
	input  logic [isaPkg::regCount-1:0] ldConstN,
	input  logic [isaPkg::regCount-1:0] incN,
	input  logic [isaPkg::regCount-1:0] decN,
	// read selects
	input  logic [isaPkg::regIdxBits-1:0] aSel,
	input  logic [isaPkg::regIdxBits-1:0] bSel,
	input  logic [isaPkg::regIdxBits-1:0] mSel,
	input  logic [isaPkg::regIdxBits-1:0] addrRegSel,
	input  logic mEnN,
	input  logic bFromConstN,
	input  dpPkg::addrSrc_t addrSrc,
	output logic [wordBits-1:0] aluA,
	output logic [wordBits-1:0] aluB,
	output logic [wordBits-1:0] memData,
	output logic [wordBits-1:0] memAddr
);

	logic [wordBits-1:0] regQ [isaPkg::regCount];
	// address source split into two priority selects
	logic addrAluSelN;
	logic addrConstSelN;

	assign addrAluSelN = (addrSrc == dpPkg::SRC_ALU) ? 1'b0 : 1'b1;
	assign addrConstSelN = (addrSrc == dpPkg::SRC_CONST) ? 1'b0 : 1'b1;

	assign aluA = regQ[aSel];
	// B from constant for immediate ops
	assign aluB = (!bFromConstN) ? inConst : regQ[bSel];
	// data bus reads zero when not enabled
	assign memData = (!mEnN) ? regQ[mSel] : '0;

	// ALU over constant over register
	always_comb
	begin
		if (!addrAluSelN)
			memAddr = inAlu;
		else if (!addrConstSelN)
			memAddr = inConst;
		else
			memAddr = regQ[addrRegSel];
	end

	// one cell per register
	for (genvar i = 0; i < isaPkg::regCount; i++)
	begin : genCell
		regCell #(.wordBits(wordBits)) u_cell
		(
			.CLK      (CLK),
			.arstN    (arstN),
			.inAlu    (inAlu),
			.inMem    (inMem),
			.inConst  (inConst),
			.ldAluN   (ldAluN[i]),
			.ldMemN   (ldMemN[i]),
			.ldConstN (ldConstN[i]),
			.incN     (incN[i]),
			.decN     (decN[i]),
			.q        (regQ[i])
		);
	end

endmodule

/* hw/instrDecode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decoder
// one word in, strobes, selects and ALU op out
// everything held inactive in reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module instrDecode
#(
	parameter int wordBits = 16
)
(
	input  logic arstN,
	input  logic [isaPkg::instrBits-1:0] instr,
	// destination strobes, active low
	output logic [isaPkg::regCount-1:0] ldAluN,
	output logic [isaPkg::regCount-1:0] ldMemN,
	output logic [isaPkg::regCount-1:0] ldConstN,
	output logic [isaPkg::regCount-1:0] incN,
	output logic [isaPkg::regCount-1:0] decN,
	output logic [isaPkg::regIdxBits-1:0] aSel,
	output logic [isaPkg::regIdxBits-1:0] bSel,
	output logic [isaPkg::regIdxBits-1:0] mSel,
	output logic [isaPkg::regIdxBits-1:0] addrRegSel,
	output logic mEnN,
	output logic bFromConstN,
	output dpPkg::addrSrc_t addrSrc,
	output dpPkg::aluOp_t aluOp,
	output logic [wordBits-1:0] constVal,
	output logic memWe
);

	localparam logic [isaPkg::regCount-1:0] destBit0 = 1;

	isaPkg::instrWord_t iw;
	logic [isaPkg::regCount-1:0] rdMaskN;

	assign iw = instr;
	// rd as a one-hot, active low
	assign rdMaskN = ~(destBit0 << iw.regForm.rd);
	// constant from the immediate view, sign-extended
	assign constVal =
		{{(wordBits - isaPkg::immBits){iw.immForm.imm[isaPkg::immBits-1]}}, iw.immForm.imm};

	always_comb
	begin
		ldAluN = '1;
		ldMemN = '1;
		ldConstN = '1;
		incN = '1;
		decN = '1;
		aSel = '0;
		bSel = '0;
		mSel = '0;
		addrRegSel = '0;
		mEnN = 1'b1;
		bFromConstN = 1'b1;
		addrSrc = dpPkg::SRC_REG;
		aluOp = dpPkg::PASSB;
		memWe = 1'b0;
		if (arstN)
		begin
			// register fields, same bits in either view
			aSel = iw.regForm.ra;
			bSel = iw.regForm.rb;
			mSel = iw.regForm.rd;
			addrRegSel = iw.regForm.ra;
			case (iw.regForm.op)
				isaPkg::ADD:
				begin
					ldAluN = rdMaskN;
					aluOp = dpPkg::ADD;
					addrSrc = dpPkg::SRC_ALU;
				end
				isaPkg::SUB:
				begin
					ldAluN = rdMaskN;
					aluOp = dpPkg::SUB;
					addrSrc = dpPkg::SRC_ALU;
				end
				isaPkg::AND:
				begin
					ldAluN = rdMaskN;
					aluOp = dpPkg::AND;
					addrSrc = dpPkg::SRC_ALU;
				end
				isaPkg::OR:
				begin
					ldAluN = rdMaskN;
					aluOp = dpPkg::OR;
					addrSrc = dpPkg::SRC_ALU;
				end
				isaPkg::XOR:
				begin
					ldAluN = rdMaskN;
					aluOp = dpPkg::XOR;
					addrSrc = dpPkg::SRC_ALU;
				end
				// ra plus constant
				isaPkg::ADDI:
				begin
					ldAluN = rdMaskN;
					aluOp = dpPkg::ADD;
					bFromConstN = 1'b0;
				end
				// constant also shows on aluOut via pass-B
				isaPkg::LDI:
				begin
					ldConstN = rdMaskN;
					bFromConstN = 1'b0;
				end
				// address from ra, data from memIn
				isaPkg::LD:
					ldMemN = rdMaskN;
				isaPkg::ST:
				begin
					mEnN = 1'b0;
					memWe = 1'b1;
				end
				// absolute address from the constant
				isaPkg::STA:
				begin
					mEnN = 1'b0;
					memWe = 1'b1;
					addrSrc = dpPkg::SRC_CONST;
				end
				isaPkg::INC:
					incN = rdMaskN;
				isaPkg::DEC:
					decN = rdMaskN;
				// NOP and unused codes change nothing
				default:
					aluOp = dpPkg::PASSB;
			endcase
		end
	end

endmodule

/* hw/aluUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-operand ALU
// combinational, wraps at the word width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module aluUnit
#(
	parameter int wordBits = 16
)
(
	input  logic [wordBits-1:0] a,
	input  logic [wordBits-1:0] b,
	input  dpPkg::aluOp_t aluOp,
	output logic [wordBits-1:0] result
);

	always_comb
	begin
		case (aluOp)
			// carry out dropped
			dpPkg::ADD:
				result = a + b;
			// borrow dropped, wraps below zero
			dpPkg::SUB:
				result = a - b;
			dpPkg::AND:
				result = a & b;
			dpPkg::OR:
				result = a | b;
			dpPkg::XOR:
				result = a ^ b;
			dpPkg::PASSB:
				result = b;
			// spare codes behave as pass-B
			default:
				result = b;
		endcase
	end

endmodule

/* hw/dataPath.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register machine datapath top
// decoder, register file and ALU, one instruction per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module dataPath
#(
	parameter int wordBits = 16
)
(
	input  logic CLK,
	input  logic arstN,
	input  logic [isaPkg::instrBits-1:0] instr,
	// read data from the external memory model
	input  logic [wordBits-1:0] memIn,
	output logic [wordBits-1:0] memAddr,
	output logic [wordBits-1:0] memData,
	output logic memWe,
	output logic [wordBits-1:0] aluOut
);

	// decoder to register file
	logic [isaPkg::regCount-1:0] ldAluN;
	logic [isaPkg::regCount-1:0] ldMemN;
	logic [isaPkg::regCount-1:0] ldConstN;
	logic [isaPkg::regCount-1:0] incN;
	logic [isaPkg::regCount-1:0] decN;
	logic [isaPkg::regIdxBits-1:0] aSel;
	logic [isaPkg::regIdxBits-1:0] bSel;
	logic [isaPkg::regIdxBits-1:0] mSel;
	logic [isaPkg::regIdxBits-1:0] addrRegSel;
	logic mEnN;
	logic bFromConstN;
	dpPkg::addrSrc_t addrSrc;
	logic [wordBits-1:0] constVal;
	// operands and result
	dpPkg::aluOp_t aluOp;
	logic [wordBits-1:0] aluA;
	logic [wordBits-1:0] aluB;
	logic [wordBits-1:0] result;

	// result written back and seen outside
	assign aluOut = result;

	instrDecode #(.wordBits(wordBits)) u_decode
	(
		.arstN       (arstN),
		.instr       (instr),
		.ldAluN      (ldAluN),
		.ldMemN      (ldMemN),
		.ldConstN    (ldConstN),
		.incN        (incN),
		.decN        (decN),
		.aSel        (aSel),
		.bSel        (bSel),
		.mSel        (mSel),
		.addrRegSel  (addrRegSel),
		.mEnN        (mEnN),
		.bFromConstN (bFromConstN),
		.addrSrc     (addrSrc),
		.aluOp       (aluOp),
		.constVal    (constVal),
		.memWe       (memWe)
	);

	regFile #(.wordBits(wordBits)) u_regs
	(
		.CLK         (CLK),
		.arstN       (arstN),
		.inAlu       (result),
		.inMem       (memIn),
		.inConst     (constVal),
		.ldAluN      (ldAluN),
		.ldMemN      (ldMemN),
		.ldConstN    (ldConstN),
		.incN        (incN),
		.decN        (decN),
		.aSel        (aSel),
		.bSel        (bSel),
		.mSel        (mSel),
		.addrRegSel  (addrRegSel),
		.mEnN        (mEnN),
		.bFromConstN (bFromConstN),
		.addrSrc     (addrSrc),
		.aluA        (aluA),
		.aluB        (aluB),
		.memData     (memData),
		.memAddr     (memAddr)
	);

	aluUnit #(.wordBits(wordBits)) u_alu
	(
		.a      (aluA),
		.b      (aluB),
		.aluOp  (aluOp),
		.result (result)
	);

endmodule

/* tests/dataPath_props.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file properties
// strobe exclusivity, idle registers hold, quiet reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module dataPath_props
#(
	parameter int wordBits = 16
)
(
	input  logic CLK,
	input  logic arstN,
	input  logic [isaPkg::regCount-1:0] ldAluN,
	input  logic [isaPkg::regCount-1:0] ldMemN,
	input  logic [isaPkg::regCount-1:0] ldConstN,
	input  logic [isaPkg::regCount-1:0] incN,
	input  logic [isaPkg::regCount-1:0] decN,
	input  logic [wordBits-1:0] regQ [isaPkg::regCount]
);

	// a bit set where one register sees two loads
	logic [isaPkg::regCount-1:0] loadClash;

	assign loadClash = (~ldAluN & ~ldMemN) | (~ldAluN & ~ldConstN) | (~ldMemN & ~ldConstN);

	loadOneHot: assert property (@(posedge CLK) disable iff (!arstN) loadClash == '0)
		else $error("more than one load strobe active on a register");

	// no strobe on a register, value kept over the edge
	for (genvar i = 0; i < isaPkg::regCount; i++)
	begin : genHold
		regHolds: assert property (@(posedge CLK) disable iff (!arstN)
			(ldAluN[i] && ldMemN[i] && ldConstN[i] && incN[i] && decN[i])
			|=> $stable(regQ[i]))
			else $error("register %0d changed with no strobe active", i);
	end

	strobesQuietInReset: assert property (@(posedge CLK)
		!arstN |-> (&ldAluN && &ldMemN && &ldConstN && &incN && &decN))
		else $error("register strobe active during reset");

endmodule

bind regFile dataPath_props #(.wordBits(wordBits)) u_props
(
	.CLK      (CLK),
	.arstN    (arstN),
	.ldAluN   (ldAluN),
	.ldMemN   (ldMemN),
	.ldConstN (ldConstN),
	.incN     (incN),
	.decN     (decN),
	.regQ     (regQ)
);

/* tests/dataPathTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the datapath top
// replays instruction rows from the stim file, checks all outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module dataPathTb;

	localparam int wordBits = 16;
	localparam int rowWords = 6;
	localparam int maxRows = 64;
	localparam int resetCycles = 16;

	logic CLK;
	logic arstN;
	logic [15:0] instr;
	logic [wordBits-1:0] memIn;
	logic [wordBits-1:0] memAddr;
	logic [wordBits-1:0] memData;
	logic memWe;
	logic [wordBits-1:0] aluOut;

	// instr, memIn, aluOut, memAddr, memData, memWe per row
	logic [15:0] stimMem [0:rowWords*maxRows-1];
	int fd;
	int nVec;
	int errCount;
	int cycleCount;
	// set to the real limit once the rows are counted
	int cycleLimit = 1000;

	dataPath #(.wordBits(wordBits)) u_dut
	(
		.CLK     (CLK),
		.arstN   (arstN),
		.instr   (instr),
		.memIn   (memIn),
		.memAddr (memAddr),
		.memData (memData),
		.memWe   (memWe),
		.aluOut  (aluOut)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// watchdog
	initial
	begin
		cycleCount = 0;
		while (cycleCount <= cycleLimit)
		begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", cycleLimit);
		$display("Checks failed");
		$finish;
	end

	// compare one row's expected outputs
	task automatic checkRow(input int row);
		int b;
		b = row * rowWords;
		if (aluOut !== stimMem[b+2])
		begin
			$display("[FAIL] %0t row %0d instr %h: aluOut %h, expected %h",
				$time, row, instr, aluOut, stimMem[b+2]);
			errCount++;
		end
		if (memAddr !== stimMem[b+3])
		begin
			$display("[FAIL] %0t row %0d instr %h: memAddr %h, expected %h",
				$time, row, instr, memAddr, stimMem[b+3]);
			errCount++;
		end
		if (memData !== stimMem[b+4])
		begin
			$display("[FAIL] %0t row %0d instr %h: memData %h, expected %h",
				$time, row, instr, memData, stimMem[b+4]);
			errCount++;
		end
		if (memWe !== stimMem[b+5][0])
		begin
			$display("[FAIL] %0t row %0d instr %h: memWe %b, expected %b",
				$time, row, instr, memWe, stimMem[b+5][0]);
			errCount++;
		end
	endtask

	initial
	begin
		arstN = 1'b0;
		// LDI r1,1 would load r1 unless reset gates the strobes
		instr = 16'h6201;
		memIn = '0;
		errCount = 0;
		nVec = 0;
		// sentinel fill, never a legal memWe column value
		for (int a = 0; a < rowWords * maxRows; a++)
			stimMem[a] = 16'hf000 | 16'(a);
		fd = $fopen("tests/dataPathStim.mem", "r");
		if (fd != 0)
		begin
			$fclose(fd);
			$readmemh("tests/dataPathStim.mem", stimMem);
		end
		// rows end at the first memWe slot that is not 0 or 1
		while (nVec < maxRows && stimMem[nVec*rowWords+5] <= 16'd1)
			nVec++;
		cycleLimit = resetCycles + nVec + 20;
		repeat (resetCycles - 1) @(posedge CLK);
		// a store raises memWe unless reset holds it low
		@(negedge CLK);
		instr = 16'h8000;
		#3;
		if (memWe !== 1'b0)
		begin
			$display("[FAIL] %0t memWe high while reset was held", $time);
			errCount++;
		end
		@(negedge CLK);
		arstN = 1'b1;
		instr = 16'hf000;
		if (nVec == 0)
		begin
			$display("stimulus file tests/dataPathStim.mem is empty or could not be read");
			errCount++;
		end
		// NOP with ra and rb both on register k, all read zero
		for (int k = 0; k < isaPkg::regCount; k++)
		begin
			@(negedge CLK);
			instr = 16'hf000 | 16'(k << 6) | 16'(k << 3);
			#3;
			if (aluOut !== '0 || memAddr !== '0)
			begin
				$display("[FAIL] %0t r%0d after reset: aluOut %h, memAddr %h, expected 0000",
					$time, k, aluOut, memAddr);
				errCount++;
			end
		end
		for (int r = 0; r < nVec; r++)
		begin
			@(negedge CLK);
			instr = stimMem[r*rowWords];
			memIn = stimMem[r*rowWords+1];
			// just ahead of the write-back edge
			#3;
			checkRow(r);
		end
		$display("rows run: %0d, errors: %0d", nVec, errCount);
		if (errCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* tests/dataPathStim.mem */
// one row per cycle, hex: instr memIn aluOut memAddr memData memWe
// register contents after each row are noted at the line end
f000 0000 0000 0000 0000 0 // NOP, r0 reads zero after reset
6205 0000 0005 0000 0000 0 // LDI r1,5
643d 0000 fffd 0000 0000 0 // LDI r2,-3
0650 0000 0002 0002 0000 0 // ADD r3,r1,r2 wraps to 2
1850 0000 0008 0008 0000 0 // SUB r4,r1,r2 = 8
1ae0 0000 fffa fffa 0000 0 // SUB r5,r3,r4 wraps below zero
2c50 0000 0005 0005 0000 0 // AND r6,r1,r2
3d08 0000 000d 000d 0000 0 // OR r6,r4,r1
4f90 0000 fff0 fff0 0000 0 // XOR r7,r6,r2
57fe 0000 ffee fff0 0000 0 // ADDI r3,r7,-2
f018 0000 ffee 0000 0000 0 // NOP reads r3 back
6014 0000 0014 0000 0000 0 // LDI r0,20
7200 beef 0014 0014 0000 0 // LD r1,[r0]
8200 1234 0014 0014 beef 1 // ST r1,[r0]
9c15 0000 fffd 0015 000d 1 // STA r6,[21]
a400 0000 0014 0014 0000 0 // INC r2 to fffe
6a00 0000 0000 0014 0000 0 // LDI r5,0
ba00 0000 0014 0014 0000 0 // DEC r5 wraps to ffff
a800 0000 0014 0014 0000 0 // INC r4 to 9
f0a8 0000 ffff fffe 0000 0 // NOP reads r5 and r2
f060 0000 0009 beef 0000 0 // NOP reads r4 and r1
aa00 0000 0014 0014 0000 0 // INC r5 wraps to 0
f1e8 0000 0000 fff0 0000 0 // NOP reads r5 and r7

/* dataPath.f */
hw/isaPkg.sv
hw/dpPkg.sv
hw/regCell.sv
hw/regFile.sv
hw/instrDecode.sv
hw/aluUnit.sv
hw/dataPath.sv
tests/dataPath_props.sv
tests/dataPathTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module dataPathTb -f dataPath.f

out=$(./obj_dir/VdataPathTb 2>&1) || true
echo "$out"

# status follows the pass line
echo "$out" | grep -q "^All checks passed$"
